/* Bender.yml */
package:
  name: uart_cmd

sources:
  - include_dirs:
      - .
    files:
      - uart_cmd_pkg.sv
      - uart_tx_frame.sv
      - uart_rx_frame.sv
      - uart_cmd_channel.sv
      - cmd_dispatch.sv
      - read_collect.sv
      - uart_cmd_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - tb_uart_cmd.sv

/* all.f */
+incdir+.
uart_cmd_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_channel.sv
cmd_dispatch.sv
read_collect.sv
uart_cmd_top.sv
tb_clock.sv
tb_uart_cmd.sv

/* cmd_dispatch.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module cmd_dispatch
  import uart_cmd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_vld,
  input  ch_idx_t                      cmd_ch,
  output logic                         cmd_rdy,
  input  logic [`UART_CMD_NUM_CH-1:0]  chan_idle,
  output logic [`UART_CMD_NUM_CH-1:0]  chan_start
);

  localparam int NUM_CH = `UART_CMD_NUM_CH;

  logic ch_ok;
  logic xfer;

  // guard the lookup when the index range is wider than the lane count
  assign ch_ok   = (int'(cmd_ch) < NUM_CH);
  assign cmd_rdy = ch_ok && chan_idle[cmd_ch];
  assign xfer    = cmd_vld && cmd_rdy;

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      chan_start[i] = xfer && (cmd_ch == ch_idx_t'(i));
    end
  end

  // host must only address existing lanes
  a_ch_in_range : assert property (
    @(posedge clk) disable iff (!rst_n) cmd_vld |-> ch_ok
  );

endmodule

`default_nettype wire

/* read_collect.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module read_collect
  import uart_cmd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [`UART_CMD_NUM_CH-1:0]  res_vld,
  input  byte_t                        res_data [`UART_CMD_NUM_CH],
  input  logic [`UART_CMD_NUM_CH-1:0]  res_err,
  output logic [`UART_CMD_NUM_CH-1:0]  res_take,
  output logic                         read_vld,
  input  logic                         read_rdy,
  output byte_t                        read_data,
  output logic                         read_err,
  output ch_idx_t                      read_ch
);

  localparam int NUM_CH = `UART_CMD_NUM_CH;

  ch_idx_t last_q;
  ch_idx_t pick;
  logic    found;
  logic    can_load;

  assign can_load = !read_vld || read_rdy;

  // search starts one past the last granted lane
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = last_q;
    for (int k = 1; k <= NUM_CH; k++) begin
      idx = (int'(last_q) + k) % NUM_CH;
      if (!found && res_vld[idx]) begin
        found = 1'b1;
        pick  = ch_idx_t'(idx);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      res_take[i] = can_load && found && (pick == ch_idx_t'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_vld <= 1'b0;
      last_q   <= ch_idx_t'(NUM_CH - 1);
    end else if (can_load) begin
      read_vld <= found;
      if (found) last_q <= pick;
    end
  end

  always_ff @(posedge clk) begin
    if (can_load && found) begin
      read_data <= res_data[pick];
      read_err  <= res_err[pick];
      read_ch   <= pick;
    end
  end

  a_hold_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (read_vld && !read_rdy) |=> (read_vld && $stable(read_data) && $stable(read_ch))
  );

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

`default_nettype wire

/* tb_uart_cmd.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module tb_uart_cmd
  import uart_cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CH           = `UART_CMD_NUM_CH;
  localparam int CPB              = `UART_CMD_CLKS_PER_BIT;
  localparam int FRAME_WAIT       = 8 * CPB;
  localparam int RESULT_WAIT      = (`UART_CMD_REPLY_BITS + 16) * CPB;
  localparam int REPLY_GOOD       = 0;
  localparam int REPLY_BAD_PARITY = 1;
  localparam int REPLY_NONE       = 2;

  logic              clk;
  logic              rst_n;
  logic              cmd_vld;
  logic              cmd_rdy;
  cmd_t              cmd_data;
  ch_idx_t           cmd_ch;
  logic [NUM_CH-1:0] tx;
  logic [NUM_CH-1:0] rx;
  logic              read_vld;
  logic              read_rdy;
  byte_t             read_data;
  logic              read_err;
  ch_idx_t           read_ch;

  int          n_mismatch;
  int          n_timeout;
  logic [31:0] rng_state;

  tb_clock u_clock (
    .clk (clk)
  );

  uart_cmd_top u_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cmd_data  (cmd_data),
    .cmd_ch    (cmd_ch),
    .tx        (tx),
    .rx        (rx),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .read_ch   (read_ch)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // peripheral register file returns address xor 5a
  function automatic byte_t reg_value(input logic [6:0] addr);
    return {1'b0, addr} ^ 8'h5A;
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      n_mismatch++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    n_timeout++;
    $display("timed out at %0t while waiting for %s", $time, what);
  endtask

  // decode one frame from a tx lane, sampling each bit near its middle
  task automatic recv_frame(input int lane, output byte_t data, output logic par,
                            output logic stop, output logic got);
    int n;
    n    = 0;
    data = '0;
    par  = 1'b0;
    stop = 1'b0;
    while (tx[lane] !== 1'b0 && n < FRAME_WAIT) begin
      @(negedge clk);
      n++;
    end
    got = (tx[lane] === 1'b0);
    if (!got) begin
      report_timeout($sformatf("a start bit on tx%0d", lane));
    end else begin
      repeat (CPB / 2 - 1) @(negedge clk);
      check($sformatf("tx%0d start bit", lane), tx[lane], 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        data[i] = tx[lane];
      end
      repeat (CPB) @(negedge clk);
      par = tx[lane];
      repeat (CPB) @(negedge clk);
      stop = tx[lane];
    end
  endtask

  task automatic send_frame(input int lane, input byte_t data, input logic flip);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ flip, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(negedge clk);
      rx[lane] = bits[i];
      repeat (CPB - 1) @(negedge clk);
    end
  endtask

  // peripheral side of one command with two frames in and an optional reply out
  task automatic serve_lane(input int lane, input cmd_t cmd, input int mode);
    byte_t d;
    byte_t want;
    logic  par;
    logic  stop;
    logic  got;
    for (int f = 0; f < 2; f++) begin
      want = (f == 0) ? cmd[15:8] : cmd[7:0];
      recv_frame(lane, d, par, stop, got);
      if (got) begin
        check($sformatf("tx%0d byte %0d", lane, f), d, want);
        check($sformatf("tx%0d parity %0d", lane, f), ^{d, par}, 1'b1);
        check($sformatf("tx%0d stop %0d", lane, f), stop, 1'b1);
      end
    end
    if (cmd[15] && mode != REPLY_NONE) begin
      repeat (CPB) @(negedge clk);
      send_frame(lane, reg_value(cmd[14:8]), mode == REPLY_BAD_PARITY);
    end
  endtask

  task automatic send_cmd(input int ch, input cmd_t cmd);
    int n;
    @(negedge clk);
    cmd_vld  = 1'b1;
    cmd_ch   = ch_idx_t'(ch);
    cmd_data = cmd;
    n = 0;
    #1;
    while (!cmd_rdy && n < RESULT_WAIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (cmd_rdy) begin
      @(posedge clk);
    end else begin
      report_timeout($sformatf("cmd_rdy on channel %0d", ch));
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic get_result(output ch_idx_t ch, output byte_t data, output logic err,
                            output logic got);
    int n;
    n = 0;
    @(negedge clk);
    read_rdy = 1'b1;
    while (!read_vld && n < RESULT_WAIT) begin
      @(negedge clk);
      n++;
    end
    got  = read_vld;
    ch   = read_ch;
    data = read_data;
    err  = read_err;
    if (!got) begin
      report_timeout("read_vld");
    end
    @(negedge clk);
    read_rdy = 1'b0;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check("tx", tx, {NUM_CH{1'b1}});
    check("read_vld", read_vld, 1'b0);
    for (int i = 0; i < NUM_CH; i++) begin
      @(negedge clk);
      cmd_ch = ch_idx_t'(i);
      #1;
      check($sformatf("cmd_rdy ch%0d", i), cmd_rdy, 1'b1);
    end
  endtask

  task automatic test_write(input int ch);
    cmd_t        cmd;
    logic [31:0] r;
    r   = next_rand();
    cmd = {1'b0, r[14:0]};
    fork
      send_cmd(ch, cmd);
      serve_lane(ch, cmd, REPLY_GOOD);
    join
    // no result and the lane is free again
    repeat (2 * CPB) begin
      @(negedge clk);
      check("read_vld", read_vld, 1'b0);
    end
    cmd_ch = ch_idx_t'(ch);
    #1;
    check($sformatf("cmd_rdy ch%0d after write", ch), cmd_rdy, 1'b1);
  endtask

  task automatic run_read(input int ch, input int mode);
    cmd_t        cmd;
    logic [31:0] r;
    ch_idx_t     rch;
    byte_t       rdata;
    logic        rerr;
    logic        got;
    r   = next_rand();
    cmd = {1'b1, r[14:0]};
    fork
      send_cmd(ch, cmd);
      serve_lane(ch, cmd, mode);
    join
    get_result(rch, rdata, rerr, got);
    if (got) begin
      check("read_ch", rch, ch);
      check("read_err", rerr, mode != REPLY_GOOD);
      if (mode == REPLY_GOOD) begin
        check("read_data", rdata, reg_value(cmd[14:8]));
      end else if (mode == REPLY_NONE) begin
        check("read_data", rdata, 8'h00);
      end
    end
  endtask

  task automatic test_parallel();
    cmd_t        cmds [NUM_CH];
    int          seen [NUM_CH];
    logic [31:0] r;
    int          n;
    int          got_n;
    int          hold_ch;
    for (int i = 0; i < NUM_CH; i++) begin
      r       = next_rand();
      cmds[i] = {1'b1, r[14:0]};
      seen[i] = 0;
    end
    @(negedge clk);
    read_rdy = 1'b0;
    for (int i = 0; i < NUM_CH; i++) begin
      fork
        automatic int   l = i;
        automatic cmd_t c = cmds[i];
        serve_lane(l, c, REPLY_GOOD);
      join_none
    end
    for (int i = 0; i < NUM_CH; i++) begin
      send_cmd(i, cmds[i]);
    end
    wait fork;
    // one result sits in the output register while the other lanes hold theirs
    repeat (CPB) @(negedge clk);
    n = 0;
    while (!read_vld && n < RESULT_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!read_vld) begin
      report_timeout("the first parallel result");
    end
    hold_ch  = (int'(read_ch) + 1) % NUM_CH;
    cmd_vld  = 1'b1;
    cmd_ch   = ch_idx_t'(hold_ch);
    cmd_data = '0;
    repeat (2 * CPB) begin
      #1;
      check($sformatf("cmd_rdy held ch%0d", hold_ch), cmd_rdy, 1'b0);
      @(negedge clk);
    end
    cmd_vld = 1'b0;
    n     = 0;
    got_n = 0;
    while (got_n < NUM_CH && n < RESULT_WAIT) begin
      @(negedge clk);
      r        = next_rand();
      read_rdy = r[0];
      if (read_vld && read_rdy) begin
        check($sformatf("read_data ch%0d", read_ch), read_data,
              reg_value(cmds[read_ch][14:8]));
        check("read_err", read_err, 1'b0);
        seen[read_ch]++;
        got_n++;
      end
      n++;
    end
    if (got_n < NUM_CH) begin
      report_timeout("all parallel results");
    end
    @(negedge clk);
    read_rdy = 1'b0;
    repeat (2 * CPB) @(negedge clk);
    check("read_vld after drain", read_vld, 1'b0);
    for (int i = 0; i < NUM_CH; i++) begin
      check($sformatf("results from ch%0d", i), seen[i], 1);
    end
    cmd_ch = ch_idx_t'(hold_ch);
    #1;
    check($sformatf("cmd_rdy ch%0d after take", hold_ch), cmd_rdy, 1'b1);
  endtask

  initial begin
    rng_state  = 32'h7e53;
    n_mismatch = 0;
    n_timeout  = 0;
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_data   = '0;
    cmd_ch     = '0;
    read_rdy   = 1'b0;
    rx         = '1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_write(1 % NUM_CH);
    run_read(2 % NUM_CH, REPLY_GOOD);
    run_read(3 % NUM_CH, REPLY_BAD_PARITY);
    run_read(0, REPLY_NONE);
    test_parallel();
    repeat (4) @(negedge clk);
    $display("mismatches: %0d, timeouts: %0d", n_mismatch, n_timeout);
    if (n_mismatch == 0 && n_timeout == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* uart_cmd_channel.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_channel
  import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  start,
  input  cmd_t  cmd,
  output logic  idle,
  output logic  tx,
  input  logic  rx,
  output logic  res_vld,
  output byte_t res_data,
  output logic  res_err,
  input  logic  res_take
);

  localparam bit_cnt_t TIMEOUT_CYCLES =
    bit_cnt_t'(`UART_CMD_REPLY_BITS * `UART_CMD_CLKS_PER_BIT);

  chan_state_t state_q;
  cmd_t        cmd_q;
  logic        tx_send;
  byte_t       tx_data;
  logic        tx_done;
  logic        rx_enable;
  logic        rx_start;
  logic        rx_done;
  byte_t       rx_data;
  logic        rx_err;
  logic        reply_seen_q;
  bit_cnt_t    timeout_cnt_q;
  logic        timeout;

  // high byte goes straight from the command bus so its start bit
  // shows up the cycle after acceptance
  assign tx_send = (state_q == IDLE && start) || (state_q == SEND_HI && tx_done);
  assign tx_data = (state_q == IDLE) ? cmd[15:8] : cmd_q[7:0];

  assign rx_enable = (state_q == WAIT_REPLY) && !reply_seen_q;
  assign timeout   = rx_enable && (timeout_cnt_q == TIMEOUT_CYCLES - 16'd1);

  assign idle    = (state_q == IDLE);
  assign res_vld = (state_q == HOLD);

  uart_tx_frame u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .send  (tx_send),
    .data  (tx_data),
    .busy  (),
    .done  (tx_done),
    .tx    (tx)
  );

  uart_rx_frame u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .enable     (rx_enable),
    .rx         (rx),
    .start_seen (rx_start),
    .done       (rx_done),
    .data       (rx_data),
    .err        (rx_err)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      reply_seen_q  <= 1'b0;
      timeout_cnt_q <= '0;
    end else begin
      case (state_q)
        IDLE:    if (start) state_q <= SEND_HI;
        SEND_HI: if (tx_done) state_q <= SEND_LO;
        SEND_LO: begin
          if (tx_done) begin
            state_q       <= cmd_q[15] ? WAIT_REPLY : IDLE;
            reply_seen_q  <= 1'b0;
            timeout_cnt_q <= '0;
          end
        end
        WAIT_REPLY: begin
          if (rx_start) reply_seen_q <= 1'b1;
          if (rx_done || timeout) begin
            state_q <= HOLD;
          end else if (!reply_seen_q) begin
            timeout_cnt_q <= timeout_cnt_q + 16'd1;
          end
        end
        HOLD:    if (res_take) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && start) cmd_q <= cmd;
    if (state_q == WAIT_REPLY) begin
      if (rx_done) begin
        res_data <= rx_data;
        res_err  <= rx_err;
      end else if (timeout) begin
        res_data <= '0;
        res_err  <= 1'b1;
      end
    end
  end

  a_take_when_valid : assert property (
    @(posedge clk) disable iff (!rst_n) res_take |-> res_vld
  );

endmodule

`default_nettype wire

/* uart_cmd_pkg.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

package uart_cmd_pkg;

  // host command: rd/wr flag, 7-bit address, 8-bit write data
  typedef logic [15:0] cmd_t;

  // one serial payload byte
  typedef logic [7:0] byte_t;

  // lane index
  typedef logic [`UART_CMD_CH_W-1:0] ch_idx_t;

  // cycles within a bit time, also reused for the reply timeout
  typedef logic [15:0] bit_cnt_t;

  // per-lane sequencer
  typedef enum logic [2:0] {
    IDLE,
    SEND_HI,
    SEND_LO,
    WAIT_REPLY,
    HOLD
  } chan_state_t;

endpackage

`default_nettype wire

/* uart_cmd_settings.svh */
`ifndef UART_CMD_SETTINGS_SVH
`define UART_CMD_SETTINGS_SVH

// number of serial lanes, 2 to 8
`define UART_CMD_NUM_CH 4

// width of a lane index, must cover UART_CMD_NUM_CH
`define UART_CMD_CH_W 2

// clock cycles per bit time
// kept small so simulation stays short; 4 or more
`define UART_CMD_CLKS_PER_BIT 16

// bit times a read waits for the reply start bit
`define UART_CMD_REPLY_BITS 40

`endif

/* uart_cmd_top.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         cmd_vld,
  output logic                         cmd_rdy,
  input  cmd_t                         cmd_data,
  input  ch_idx_t                      cmd_ch,
  output logic [`UART_CMD_NUM_CH-1:0]  tx,
  input  logic [`UART_CMD_NUM_CH-1:0]  rx,
  output logic                         read_vld,
  input  logic                         read_rdy,
  output byte_t                        read_data,
  output logic                         read_err,
  output ch_idx_t                      read_ch
);

  logic [`UART_CMD_NUM_CH-1:0] chan_idle;
  logic [`UART_CMD_NUM_CH-1:0] chan_start;
  logic [`UART_CMD_NUM_CH-1:0] res_vld;
  logic [`UART_CMD_NUM_CH-1:0] res_err;
  logic [`UART_CMD_NUM_CH-1:0] res_take;
  byte_t                       res_data [`UART_CMD_NUM_CH];

  cmd_dispatch u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vld    (cmd_vld),
    .cmd_ch     (cmd_ch),
    .cmd_rdy    (cmd_rdy),
    .chan_idle  (chan_idle),
    .chan_start (chan_start)
  );

  // one engine per serial lane, command bus shared
  for (genvar i = 0; i < `UART_CMD_NUM_CH; i++) begin : g_ch
    uart_cmd_channel u_channel (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (chan_start[i]),
      .cmd      (cmd_data),
      .idle     (chan_idle[i]),
      .tx       (tx[i]),
      .rx       (rx[i]),
      .res_vld  (res_vld[i]),
      .res_data (res_data[i]),
      .res_err  (res_err[i]),
      .res_take (res_take[i])
    );
  end

  read_collect u_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_vld   (res_vld),
    .res_data  (res_data),
    .res_err   (res_err),
    .res_take  (res_take),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err),
    .read_ch   (read_ch)
  );

endmodule

`default_nettype wire

/* uart_rx_frame.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  enable,
  input  logic  rx,
  output logic  start_seen,
  output logic  done,
  output byte_t data,
  output logic  err
);

  localparam bit_cnt_t CLKS_PER_BIT = bit_cnt_t'(`UART_CMD_CLKS_PER_BIT);
  localparam bit_cnt_t MID_BIT      = bit_cnt_t'(`UART_CMD_CLKS_PER_BIT / 2 - 1);

  // [0],[1] synchronizer, [2] previous synced value for edge detect
  logic [2:0] rx_sync_q;
  logic       rx_s;
  logic       active_q;
  bit_cnt_t   clk_cnt_q;
  logic [3:0] bit_idx_q;
  logic       parity_q;
  logic       sample;

  assign rx_s       = rx_sync_q[1];
  assign start_seen = enable && !active_q && rx_sync_q[2] && !rx_sync_q[1];
  assign sample     = active_q && (clk_cnt_q == MID_BIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync_q <= 3'b111;
    end else begin
      rx_sync_q <= {rx_sync_q[1:0], rx};
    end
  end

  // bit 0 start, 1..8 data, 9 parity, 10 stop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q  <= 1'b0;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start_seen) begin
        active_q  <= 1'b1;
        clk_cnt_q <= '0;
        bit_idx_q <= '0;
      end else if (active_q) begin
        if (clk_cnt_q == CLKS_PER_BIT - 16'd1) begin
          clk_cnt_q <= '0;
        end else begin
          clk_cnt_q <= clk_cnt_q + 16'd1;
        end
        if (sample) begin
          bit_idx_q <= bit_idx_q + 4'd1;
          // a glitch that is high again at mid start bit ends the frame too
          if ((bit_idx_q == 4'd0 && rx_s) || bit_idx_q == 4'd10) begin
            active_q <= 1'b0;
            done     <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_seen) begin
      parity_q <= 1'b0;
    end else if (sample) begin
      case (bit_idx_q)
        4'd0: begin
          if (rx_s) begin
            data <= '0;
            err  <= 1'b1;
          end
        end
        4'd9:  parity_q <= parity_q ^ rx_s;
        4'd10: err <= !parity_q || !rx_s;
        default: begin
          parity_q <= parity_q ^ rx_s;
          data     <= {rx_s, data[7:1]};
        end
      endcase
    end
  end

  a_done_pulse : assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  );

endmodule

`default_nettype wire

/* uart_tx_frame.sv */
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  send,
  input  byte_t data,
  output logic  busy,
  output logic  done,
  output logic  tx
);

  localparam bit_cnt_t CLKS_PER_BIT = bit_cnt_t'(`UART_CMD_CLKS_PER_BIT);

  // bits still to go after the start bit: data lsb first, parity, stop
  logic [9:0] shift_q;
  logic [3:0] bits_left_q;
  bit_cnt_t   clk_cnt_q;
  logic       running_q;
  logic       bit_end;
  logic       last_cycle;

  assign bit_end    = running_q && (clk_cnt_q == CLKS_PER_BIT - 16'd1);
  assign last_cycle = bit_end && (bits_left_q == 4'd0);

  // done marks the final stop-bit cycle
  assign done = last_cycle;
  // already free in that cycle, so a second frame can follow with no gap
  assign busy = running_q && !last_cycle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running_q   <= 1'b0;
      tx          <= 1'b1;
      clk_cnt_q   <= '0;
      bits_left_q <= '0;
    end else if (send) begin
      running_q   <= 1'b1;
      tx          <= 1'b0;
      clk_cnt_q   <= '0;
      bits_left_q <= 4'd10;
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      if (bits_left_q == 4'd0) begin
        running_q <= 1'b0;
      end else begin
        tx          <= shift_q[0];
        bits_left_q <= bits_left_q - 4'd1;
      end
    end else if (running_q) begin
      clk_cnt_q <= clk_cnt_q + 16'd1;
    end
  end

  // odd parity: xnor of the data bits
  always_ff @(posedge clk) begin
    if (send) begin
      shift_q <= {1'b1, ~^data, data};
    end else if (bit_end) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  // the lane sequencer must wait for the frame in flight
  a_no_send_while_busy : assert property (
    @(posedge clk) disable iff (!rst_n) send |-> !busy
  );

endmodule

`default_nettype wire
